// File: rtl/axil_regs_config.svh
`ifndef AXIL_REGS_CONFIG_SVH
`define AXIL_REGS_CONFIG_SVH

// bus geometry
`define AXIL_DATA_WIDTH 32
`define AXIL_ADDR_WIDTH 7
`define AXIL_STRB_WIDTH 4

// word index of the register file sits above the byte offset
`define AXIL_REG_COUNT  32
`define AXIL_IDX_WIDTH  5
`define AXIL_IDX_LSB    2

`define AXIL_RESP_OKAY  2'b00

`endif

// File: rtl/axil_regs_pkg.sv
`include "axil_regs_config.svh"

package axil_regs_pkg;

  typedef logic [`AXIL_DATA_WIDTH-1:0] axil_data_t;
  typedef logic [`AXIL_STRB_WIDTH-1:0] axil_strb_t;
  typedef logic [1:0]                  axil_resp_t;
  typedef logic [`AXIL_IDX_WIDTH-1:0]  reg_idx_t;

  typedef struct packed {
    logic [`AXIL_ADDR_WIDTH-1:0] addr;
  } axil_aw_t;

  typedef struct packed {
    axil_data_t data;
    axil_strb_t strb;
  } axil_w_t;

  typedef struct packed {
    axil_resp_t resp;
  } axil_b_t;

  typedef struct packed {
    logic [`AXIL_ADDR_WIDTH-1:0] addr;
  } axil_ar_t;

  typedef struct packed {
    axil_data_t data;
    axil_resp_t resp;
  } axil_r_t;

  // one byte-strobed write into the bank
  typedef struct packed {
    logic       en;
    reg_idx_t   idx;
    axil_data_t data;
    axil_strb_t strb;
  } reg_wr_t;

endpackage

// File: rtl/reg_bank.sv
`timescale 1ns/1ns
`include "axil_regs_config.svh"

module reg_bank (
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,
  input  axil_regs_pkg::reg_wr_t    wr,
  input  axil_regs_pkg::reg_idx_t   rd_idx,
  output axil_regs_pkg::axil_data_t rd_data
);
  import axil_regs_pkg::*;

  axil_data_t regs [`AXIL_REG_COUNT];

  // byte lanes without a strobe keep their old value
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      regs <= '{default: '0};
    end else if (wr.en) begin
      for (int lane = 0; lane < `AXIL_STRB_WIDTH; lane++) begin
        if (wr.strb[lane]) begin
          regs[wr.idx][8*lane +: 8] <= wr.data[8*lane +: 8];
        end
      end
    end
  end

  // read mux output is registered in the read channel
  assign rd_data = regs[rd_idx];

endmodule

// File: rtl/axil_write_channel.sv
`timescale 1ns/1ns
`include "axil_regs_config.svh"

module axil_write_channel (
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  input  axil_regs_pkg::axil_aw_t aw,
  input  logic                    aw_valid,
  output logic                    aw_ready,
  input  axil_regs_pkg::axil_w_t  w,
  input  logic                    w_valid,
  output logic                    w_ready,
  output axil_regs_pkg::axil_b_t  b,
  output logic                    b_valid,
  input  logic                    b_ready,
  output axil_regs_pkg::reg_wr_t  wr
);
  import axil_regs_pkg::*;

  logic wr_ready;
  logic wr_start;
  logic wr_xfer;

  // address and data are taken together, only when no response is stuck
  assign wr_start = !wr_ready && aw_valid && w_valid && (!b_valid || b_ready);
  assign wr_xfer  = wr_ready && aw_valid && w_valid;

  assign aw_ready = wr_ready;
  assign w_ready  = wr_ready;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      wr_ready <= 1'b0;
    end else begin
      wr_ready <= wr_start;
    end
  end

  // bank sees the request during the transfer cycle
  always_comb begin
    wr.en   = wr_xfer;
    wr.idx  = aw.addr[`AXIL_IDX_LSB +: `AXIL_IDX_WIDTH];
    wr.data = w.data;
    wr.strb = w.strb;
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      b_valid <= 1'b0;
    end else if (wr_xfer) begin
      b_valid <= 1'b1;
    end else if (b_ready) begin
      b_valid <= 1'b0;
    end
  end

  // no error cases
  assign b.resp = `AXIL_RESP_OKAY;

  // shared ready only helps while both valids are still offered
  a_ready_offer: assert property (
    @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    aw_ready |-> (aw_valid && w_valid)
  ) else $error("write ready without both valids");

  // a stalled response blocks the next write
  a_b_block: assert property (
    @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    (b_valid && !b_ready) |-> !aw_ready
  ) else $error("write accepted while the response was blocked");

endmodule

// File: rtl/axil_read_channel.sv
`timescale 1ns/1ns
`include "axil_regs_config.svh"

module axil_read_channel (
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,
  input  axil_regs_pkg::axil_ar_t   ar,
  input  logic                      ar_valid,
  output logic                      ar_ready,
  output axil_regs_pkg::axil_r_t    r,
  output logic                      r_valid,
  input  logic                      r_ready,
  output axil_regs_pkg::reg_idx_t   rd_idx,
  input  axil_regs_pkg::axil_data_t rd_data
);
  import axil_regs_pkg::*;

  logic rd_start;
  logic rd_xfer;

  assign rd_start = !ar_ready && ar_valid && (!r_valid || r_ready);
  assign rd_xfer  = ar_ready && ar_valid;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      ar_ready <= 1'b0;
      r_valid  <= 1'b0;
    end else begin
      ar_ready <= rd_start;
      if (rd_xfer) begin
        r_valid <= 1'b1;
      end else if (r_ready) begin
        r_valid <= 1'b0;
      end
    end
  end

  // index is latched with ar_ready so the bank output settles before the transfer
  always_ff @(posedge S_AXI_ACLK) begin
    if (rd_start) begin
      rd_idx <= ar.addr[`AXIL_IDX_LSB +: `AXIL_IDX_WIDTH];
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (rd_xfer) begin
      r.data <= rd_data;
      r.resp <= `AXIL_RESP_OKAY;
    end
  end

  // response held under back-pressure
  a_r_stable: assert property (
    @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    (r_valid && !r_ready) |=> (r_valid && $stable(r))
  ) else $error("read response changed while stalled");

endmodule

// File: rtl/axil_regs_top.sv
`timescale 1ns/1ns

module axil_regs_top (
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  input  axil_regs_pkg::axil_aw_t aw,
  input  logic                    aw_valid,
  output logic                    aw_ready,
  input  axil_regs_pkg::axil_w_t  w,
  input  logic                    w_valid,
  output logic                    w_ready,
  output axil_regs_pkg::axil_b_t  b,
  output logic                    b_valid,
  input  logic                    b_ready,
  input  axil_regs_pkg::axil_ar_t ar,
  input  logic                    ar_valid,
  output logic                    ar_ready,
  output axil_regs_pkg::axil_r_t  r,
  output logic                    r_valid,
  input  logic                    r_ready
);
  import axil_regs_pkg::*;

  reg_wr_t    wr;
  reg_idx_t   rd_idx;
  axil_data_t rd_data;

  axil_write_channel i_axil_write_channel (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .aw            (aw),
    .aw_valid      (aw_valid),
    .aw_ready      (aw_ready),
    .w             (w),
    .w_valid       (w_valid),
    .w_ready       (w_ready),
    .b             (b),
    .b_valid       (b_valid),
    .b_ready       (b_ready),
    .wr            (wr)
  );

  axil_read_channel i_axil_read_channel (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .ar            (ar),
    .ar_valid      (ar_valid),
    .ar_ready      (ar_ready),
    .r             (r),
    .r_valid       (r_valid),
    .r_ready       (r_ready),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data)
  );

  reg_bank i_reg_bank (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr            (wr),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data)
  );

endmodule

// File: tests/tb_axil_regs.sv
`timescale 1ns/1ns

module tb_axil_regs;
  import axil_regs_pkg::*;

  localparam int TIMEOUT_CYCLES = 100;
  localparam logic [1:0] RESP_OKAY = 2'b00;

  logic     S_AXI_ACLK;
  logic     S_AXI_ARESETN;
  axil_aw_t aw;
  logic     aw_valid;
  logic     aw_ready;
  axil_w_t  w;
  logic     w_valid;
  logic     w_ready;
  axil_b_t  b;
  logic     b_valid;
  logic     b_ready;
  axil_ar_t ar;
  logic     ar_valid;
  logic     ar_ready;
  axil_r_t  r;
  logic     r_valid;
  logic     r_ready;

  int seed = 32'h6a17;

  axil_regs_top i_axil_regs_top (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .aw            (aw),
    .aw_valid      (aw_valid),
    .aw_ready      (aw_ready),
    .w             (w),
    .w_valid       (w_valid),
    .w_ready       (w_ready),
    .b             (b),
    .b_valid       (b_valid),
    .b_ready       (b_ready),
    .ar            (ar),
    .ar_valid      (ar_valid),
    .ar_ready      (ar_ready),
    .r             (r),
    .r_valid       (r_valid),
    .r_ready       (r_ready)
  );

  always #5 S_AXI_ACLK = ~S_AXI_ACLK;

  task automatic stop_failed();
    $display("Simulation FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp, got);
      stop_failed();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t ns: %s expected %b got %b", $time, name, exp, got);
      stop_failed();
    end
  endtask

  // returns 1 ns past the edge where outputs have settled
  task automatic step();
    @(posedge S_AXI_ACLK);
    #1;
  endtask

  task automatic accept_write(input bit keep_valid);
    int n;
    n = 0;
    while (!aw_ready) begin
      step();
      n++;
      if (n > TIMEOUT_CYCLES) begin
        $display("timeout: aw_ready did not rise for the write to %h", aw.addr);
        stop_failed();
      end
    end
    check_bit("w_ready", w_ready, 1'b1);
    step();
    if (!keep_valid) begin
      aw_valid = 1'b0;
      w_valid  = 1'b0;
    end
    n = 0;
    while (!b_valid) begin
      step();
      n++;
      if (n > TIMEOUT_CYCLES) begin
        $display("timeout: no write response for the write to %h", aw.addr);
        stop_failed();
      end
    end
    check_value("b.resp", 32'(b.resp), 32'(RESP_OKAY));
  endtask

  task automatic release_b();
    b_ready = 1'b1;
    step();
    b_ready = 1'b0;
  endtask

  task automatic do_write(input logic [6:0] addr, input axil_data_t data,
                          input axil_strb_t strb, input int stall);
    axil_b_t held;
    aw.addr  = addr;
    w.data   = data;
    w.strb   = strb;
    aw_valid = 1'b1;
    w_valid  = 1'b1;
    // during a stall the valids stay up as a second, blocked write
    accept_write(stall > 0);
    held = b;
    for (int i = 0; i < stall; i++) begin
      step();
      check_bit("b_valid", b_valid, 1'b1);
      check_value("b", 32'(b), 32'(held));
      check_bit("aw_ready", aw_ready, 1'b0);
    end
    release_b();
    if (stall > 0) begin
      accept_write(1'b0);
      release_b();
    end
    check_bit("b_valid", b_valid, 1'b0);
  endtask

  task automatic accept_read(input bit keep_valid, input axil_data_t exp);
    int n;
    n = 0;
    while (!ar_ready) begin
      step();
      n++;
      if (n > TIMEOUT_CYCLES) begin
        $display("timeout: ar_ready did not rise for the read of %h", ar.addr);
        stop_failed();
      end
    end
    step();
    if (!keep_valid) begin
      ar_valid = 1'b0;
    end
    n = 0;
    while (!r_valid) begin
      step();
      n++;
      if (n > TIMEOUT_CYCLES) begin
        $display("timeout: no read response for the read of %h", ar.addr);
        stop_failed();
      end
    end
    check_value("r.data", r.data, exp);
    check_value("r.resp", 32'(r.resp), 32'(RESP_OKAY));
  endtask

  task automatic release_r();
    r_ready = 1'b1;
    step();
    r_ready = 1'b0;
  endtask

  task automatic do_read(input logic [6:0] addr, input axil_data_t exp, input int stall);
    axil_r_t held;
    ar.addr  = addr;
    ar_valid = 1'b1;
    accept_read(stall > 0, exp);
    held = r;
    for (int i = 0; i < stall; i++) begin
      step();
      check_bit("r_valid", r_valid, 1'b1);
      check_value("r.data", r.data, held.data);
      check_value("r.resp", 32'(r.resp), 32'(held.resp));
      check_bit("ar_ready", ar_ready, 1'b0);
    end
    release_r();
    if (stall > 0) begin
      accept_read(1'b0, exp);
      release_r();
    end
    check_bit("r_valid", r_valid, 1'b0);
  endtask

  initial begin
    int fd;
    int n;
    int stall;
    int ops;
    bit done;
    logic [7:0] op_s;
    logic [7:0] stall_s;
    logic [8*128-1:0] rest;
    logic [6:0] addr;
    axil_data_t data;
    axil_strb_t strb;
    axil_data_t exp;

    S_AXI_ACLK    = 1'b0;
    S_AXI_ARESETN = 1'b0;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar       = '0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    ops  = 0;
    done = 1'b0;

    repeat (3) @(posedge S_AXI_ACLK);
    #1;
    S_AXI_ARESETN = 1'b1;

    check_bit("aw_ready", aw_ready, 1'b0);
    check_bit("w_ready", w_ready, 1'b0);
    check_bit("ar_ready", ar_ready, 1'b0);
    check_bit("b_valid", b_valid, 1'b0);
    check_bit("r_valid", r_valid, 1'b0);

    fd = $fopen("tests/axil_regs_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/axil_regs_vectors.txt");
      stop_failed();
    end

    while (!done) begin
      n = $fscanf(fd, "%s", op_s);
      if (n != 1) begin
        done = 1'b1;
      end else if (op_s == "#") begin
        n = $fgets(rest, fd);
      end else begin
        n = $fscanf(fd, "%h %h %h %h %s", addr, data, strb, exp, stall_s);
        if (n != 5) begin
          $display("malformed line in the vector file after %0d operations", ops);
          stop_failed();
        end
        if (stall_s == "r") begin
          stall = $unsigned($random(seed)) % 6;
        end else if (stall_s >= "0" && stall_s <= "9") begin
          stall = int'(stall_s) - 48;
        end else begin
          $display("bad stall field in the vector file after %0d operations", ops);
          stop_failed();
        end
        if (op_s == "W") begin
          do_write(addr, data, strb, stall);
        end else if (op_s == "R") begin
          do_read(addr, exp, stall);
        end else begin
          $display("unknown operation in the vector file after %0d operations", ops);
          stop_failed();
        end
        ops++;
      end
    end
    $fclose(fd);

    if (ops == 0) begin
      $display("the vector file held no operations");
      stop_failed();
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

// File: tests/axil_regs_vectors.txt
# op addr data strb expect stall, hex fields, expect is unused on writes
# stall = cycles b_ready or r_ready stays low, r draws 0 to 5
R 00 00000000 0 00000000 0
R 04 00000000 0 00000000 r
R 08 00000000 0 00000000 0
R 0c 00000000 0 00000000 2
R 10 00000000 0 00000000 0
R 14 00000000 0 00000000 r
R 18 00000000 0 00000000 0
R 1c 00000000 0 00000000 2
R 20 00000000 0 00000000 0
R 24 00000000 0 00000000 r
R 28 00000000 0 00000000 0
R 2c 00000000 0 00000000 2
R 30 00000000 0 00000000 0
R 34 00000000 0 00000000 r
R 38 00000000 0 00000000 0
R 3c 00000000 0 00000000 2
R 40 00000000 0 00000000 0
R 44 00000000 0 00000000 r
R 48 00000000 0 00000000 0
R 4c 00000000 0 00000000 2
R 50 00000000 0 00000000 0
R 54 00000000 0 00000000 r
R 58 00000000 0 00000000 0
R 5c 00000000 0 00000000 2
R 60 00000000 0 00000000 0
R 64 00000000 0 00000000 r
R 68 00000000 0 00000000 0
R 6c 00000000 0 00000000 2
R 70 00000000 0 00000000 0
R 74 00000000 0 00000000 r
R 78 00000000 0 00000000 0
R 7c 00000000 0 00000000 2
W 00 a5005a00 f 00000000 0
W 04 a5015a01 f 00000000 1
W 08 a5025a02 f 00000000 r
W 0d a5035a03 f 00000000 0
W 10 a5045a04 f 00000000 0
W 14 a5055a05 f 00000000 1
W 18 a5065a06 f 00000000 r
W 1c a5075a07 f 00000000 0
W 20 a5085a08 f 00000000 0
W 24 a5095a09 f 00000000 1
W 2b a50a5a0a f 00000000 r
W 2c a50b5a0b f 00000000 0
W 30 a50c5a0c f 00000000 0
W 34 a50d5a0d f 00000000 1
W 38 a50e5a0e f 00000000 r
W 3c a50f5a0f f 00000000 0
W 40 a5105a10 f 00000000 0
W 44 a5115a11 f 00000000 1
W 48 a5125a12 f 00000000 r
W 4c a5135a13 f 00000000 0
W 50 a5145a14 f 00000000 0
W 56 a5155a15 f 00000000 1
W 58 a5165a16 f 00000000 r
W 5c a5175a17 f 00000000 0
W 60 a5185a18 f 00000000 0
W 64 a5195a19 f 00000000 1
W 68 a51a5a1a f 00000000 r
W 6c a51b5a1b f 00000000 0
W 70 a51c5a1c f 00000000 0
W 74 a51d5a1d f 00000000 1
W 78 a51e5a1e f 00000000 r
W 7c a51f5a1f f 00000000 0
R 00 00000000 0 a5005a00 0
R 04 00000000 0 a5015a01 0
R 08 00000000 0 a5025a02 r
R 0c 00000000 0 a5035a03 0
R 10 00000000 0 a5045a04 3
R 15 00000000 0 a5055a05 0
R 18 00000000 0 a5065a06 r
R 1c 00000000 0 a5075a07 0
R 20 00000000 0 a5085a08 0
R 24 00000000 0 a5095a09 3
R 28 00000000 0 a50a5a0a r
R 2c 00000000 0 a50b5a0b 0
R 30 00000000 0 a50c5a0c 0
R 34 00000000 0 a50d5a0d 0
R 38 00000000 0 a50e5a0e r
R 3c 00000000 0 a50f5a0f 3
R 40 00000000 0 a5105a10 0
R 47 00000000 0 a5115a11 0
R 48 00000000 0 a5125a12 r
R 4c 00000000 0 a5135a13 0
R 50 00000000 0 a5145a14 3
R 54 00000000 0 a5155a15 0
R 58 00000000 0 a5165a16 r
R 5c 00000000 0 a5175a17 0
R 60 00000000 0 a5185a18 0
R 64 00000000 0 a5195a19 3
R 68 00000000 0 a51a5a1a r
R 6c 00000000 0 a51b5a1b 0
R 70 00000000 0 a51c5a1c 0
R 74 00000000 0 a51d5a1d 0
R 78 00000000 0 a51e5a1e r
R 7e 00000000 0 a51f5a1f 3
W 08 11223344 1 00000000 0
R 08 00000000 0 a5025a44 r
W 32 deadbeef a 00000000 r
R 30 00000000 0 de0cbe0c 0
W 7c 01020304 6 00000000 3
R 7d 00000000 0 a502031f 1

// File: files.f
+incdir+rtl
rtl/axil_regs_pkg.sv
rtl/reg_bank.sv
rtl/axil_write_channel.sv
rtl/axil_read_channel.sv
rtl/axil_regs_top.sv
tests/tb_axil_regs.sv

// File: Makefile
SIM      ?= verilator
TOP      := tb_axil_regs
FILELIST := files.f
FLAGS    := --binary --timing --assert
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)
PASS_MSG := Simulation PASSED

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
